// File: Makefile
TOP := noc_output_port_tb
LOG := sim.log

SRCS := compile.f $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Checks failed" $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
+incdir+hdl
hdl/noc_pkg.sv
hdl/vc_fifo.sv
hdl/rr_arbiter.sv
hdl/input_module.sv
hdl/output_module.sv
hdl/noc_output_port.sv
verification/noc_output_port_asserts.sv
verification/noc_output_port_tb.sv

// File: hdl/input_module.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_settings.svh"

module input_module (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  // from link
  input  wire logic            in_valid_i,
  input  wire noc_pkg::vc_id_t in_vc_i,
  input  wire noc_pkg::flit_t  in_flit_i,
  output logic                 in_ready_o,
  // to output module
  output logic                 fin_valid_o,
  output noc_pkg::vc_id_t      fin_vc_o,
  output noc_pkg::flit_t       fin_flit_o,
  input  wire logic            fin_ready_i
);

  logic [`N_VIRT_CHN-1:0] vc_push;   // write steering
  logic [`N_VIRT_CHN-1:0] vc_pop;    // read steering
  logic [`N_VIRT_CHN-1:0] vc_empty;
  logic [`N_VIRT_CHN-1:0] vc_full;
  noc_pkg::flit_t         vc_head [`N_VIRT_CHN];  // per-vc head flit
  logic                   open_q;     // packet in progress
  noc_pkg::vc_id_t        open_vc_q;  // vc of that packet
  noc_pkg::vc_id_t        pick_vc;    // priority pick when idle
  logic                   pop_last;   // popped flit closes packet

  genvar v;
  generate
    for (v = 0; v < `N_VIRT_CHN; v++) begin : g_vc
      vc_fifo #(
        .payload_t (noc_pkg::flit_t),
        .DEPTH     (`VC_FIFO_DEPTH)
      ) u_vc_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (vc_push[v]),
        .data_i  (in_flit_i),
        .pop_i   (vc_pop[v]),
        .data_o  (vc_head[v]),
        .empty_o (vc_empty[v]),
        .full_o  (vc_full[v])
      );

      assign vc_push[v] = in_valid_i && (in_vc_i == noc_pkg::vc_id_t'(v));
      assign vc_pop[v]  = fin_valid_o && fin_ready_i && (fin_vc_o == noc_pkg::vc_id_t'(v));
    end
  endgenerate

  assign in_ready_o = !vc_full[in_vc_i];  // room in the addressed vc

  // later hits override, so scan order sets the priority
  always_comb begin : vc_pick
    pick_vc = '0;
    if (`H_PRIORITY) begin
      for (int i = 0; i < `N_VIRT_CHN; i++) begin
        if (!vc_empty[i]) pick_vc = noc_pkg::vc_id_t'(i);  // highest wins
      end
    end else begin
      for (int i = `N_VIRT_CHN - 1; i >= 0; i--) begin
        if (!vc_empty[i]) pick_vc = noc_pkg::vc_id_t'(i);  // lowest wins
      end
    end
  end

  assign fin_vc_o    = open_q ? open_vc_q : pick_vc;  // stick to open packet
  assign fin_flit_o  = vc_head[fin_vc_o];
  assign fin_valid_o = !vc_empty[fin_vc_o];           // may starve mid-packet

  assign pop_last = (fin_flit_o.type_f == noc_pkg::TAIL_FLIT) ||
                    ((fin_flit_o.type_f == noc_pkg::HEAD_FLIT) &&
                     (fin_flit_o.pkt_size == 4'(`MIN_SIZE_FLIT)));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      open_q    <= 1'b0;
      open_vc_q <= '0;
    end else if (fin_valid_o && fin_ready_i) begin
      open_q    <= !pop_last;  // single-flit head never opens
      open_vc_q <= fin_vc_o;
    end
  end

endmodule

`default_nettype wire

// File: hdl/noc_output_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_settings.svh"

module noc_output_port (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  // four ingress links
  input  wire logic            [3:0] in_valid_i,
  input  wire noc_pkg::vc_id_t [3:0] in_vc_i,
  input  wire noc_pkg::flit_t  [3:0] in_flit_i,
  output logic                 [3:0] in_ready_o,
  // egress link
  output logic                       out_valid_o,
  output noc_pkg::vc_id_t            out_vc_o,
  output noc_pkg::flit_t             out_flit_o,
  input  wire logic                  out_ready_i
);

  logic            [3:0] fin_valid;     // input -> output module
  noc_pkg::vc_id_t [3:0] fin_vc;
  noc_pkg::flit_t  [3:0] fin_flit;
  logic            [3:0] fin_ready;     // output module -> input
  logic                  fout_push;     // switch into egress
  noc_pkg::egress_flit_t fout_flit;
  logic                  egress_empty;
  logic                  egress_full;
  noc_pkg::egress_flit_t egress_head;   // head of egress buffer

  genvar k;
  generate
    for (k = 0; k < 4; k++) begin : g_in
      input_module u_input_module (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i[k]),
        .in_vc_i     (in_vc_i[k]),
        .in_flit_i   (in_flit_i[k]),
        .in_ready_o  (in_ready_o[k]),
        .fin_valid_o (fin_valid[k]),
        .fin_vc_o    (fin_vc[k]),
        .fin_flit_o  (fin_flit[k]),
        .fin_ready_i (fin_ready[k])
      );
    end
  endgenerate

  output_module u_output_module (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .fin_valid_i  (fin_valid),
    .fin_vc_i     (fin_vc),
    .fin_flit_i   (fin_flit),
    .fin_ready_o  (fin_ready),
    .fout_push_o  (fout_push),
    .fout_flit_o  (fout_flit),
    .fout_ready_i (!egress_full)    // back-pressure from egress
  );

  vc_fifo #(
    .payload_t (noc_pkg::egress_flit_t),
    .DEPTH     (`EGRESS_DEPTH)
  ) u_egress_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .push_i  (fout_push),
    .data_i  (fout_flit),
    .pop_i   (out_ready_i),         // pop on empty ignored inside
    .data_o  (egress_head),
    .empty_o (egress_empty),
    .full_o  (egress_full)
  );

  assign out_valid_o = !egress_empty;
  assign out_vc_o    = egress_head.vc_id;
  assign out_flit_o  = egress_head.flit;

endmodule

`default_nettype wire

// File: hdl/noc_pkg.sv
`default_nettype none

`include "noc_settings.svh"

package noc_pkg;

  // flit kinds seen on the link
  typedef enum logic [1:0] {
    HEAD_FLIT = 2'b00,  // opens packet, pkt_size valid
    BODY_FLIT = 2'b01,  // middle of packet
    TAIL_FLIT = 2'b10   // closes multi-flit packet
  } flit_type_t;

  // vc index, at least one bit wide
  typedef logic [$clog2((`N_VIRT_CHN > 1) ? `N_VIRT_CHN : 2)-1:0] vc_id_t;

  // flit as stored in the input buffers
  typedef struct packed {
    flit_type_t              type_f;    // head/body/tail
    logic [3:0]              pkt_size;  // flits after the head
    logic [`FLIT_DATA_W-1:0] data;      // payload
  } flit_t;

  // flit tagged with the vc it leaves on
  typedef struct packed {
    vc_id_t vc_id;  // output vc
    flit_t  flit;   // switched flit
  } egress_flit_t;

endpackage

`default_nettype wire

// File: hdl/noc_settings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// router output port configuration

// virtual channels per link
`define N_VIRT_CHN     2

// payload bits carried by every flit
`define FLIT_DATA_W    32

`define VC_FIFO_DEPTH  4  // entries per input vc buffer
`define EGRESS_DEPTH   2  // entries in the egress buffer

// vc priority direction, 1 means highest vc index wins
`define H_PRIORITY     1

// pkt_size of a head that is also the last flit
`define MIN_SIZE_FLIT  0

`endif

// File: hdl/output_module.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_settings.svh"

module output_module (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  // from the four input modules
  input  wire logic            [3:0] fin_valid_i,
  input  wire noc_pkg::vc_id_t [3:0] fin_vc_i,
  input  wire noc_pkg::flit_t  [3:0] fin_flit_i,
  output logic                 [3:0] fin_ready_o,
  // to egress buffer
  output logic                       fout_push_o,
  output noc_pkg::egress_flit_t      fout_flit_o,
  input  wire logic                  fout_ready_i   // egress not full
);

  logic [`N_VIRT_CHN-1:0][3:0] vc_req;      // requests sorted by vc
  logic [`N_VIRT_CHN-1:0][3:0] vc_grant;    // per-vc arbiter grants
  logic [`N_VIRT_CHN-1:0]      vc_pkt_end;  // arbiter release pulses
  logic                        act_vld;     // some vc has a grant
  noc_pkg::vc_id_t             act_vc;      // vc switched this cycle
  logic [1:0]                  win_idx;     // winning input
  noc_pkg::flit_t              win_flit;
  logic                        win_last;    // winner closes its packet

  always_comb begin : req_sort
    vc_req = '0;
    for (int v = 0; v < `N_VIRT_CHN; v++) begin
      for (int k = 0; k < 4; k++) begin
        vc_req[v][k] = fin_valid_i[k] && (fin_vc_i[k] == noc_pkg::vc_id_t'(v));
      end
    end
  end

  genvar g;
  generate
    for (g = 0; g < `N_VIRT_CHN; g++) begin : g_arb
      rr_arbiter #(
        .N_OF_INPUTS (4)
      ) u_rr_arbiter (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    (vc_req[g]),
        .update_i (vc_pkt_end[g]),
        .grant_o  (vc_grant[g])
      );
    end
  endgenerate

  // vc priority among granted vcs, last hit wins
  always_comb begin : vc_select
    act_vld = 1'b0;
    act_vc  = '0;
    if (`H_PRIORITY) begin
      for (int v = 0; v < `N_VIRT_CHN; v++) begin
        if (|vc_grant[v]) begin
          act_vld = 1'b1;
          act_vc  = noc_pkg::vc_id_t'(v);
        end
      end
    end else begin
      for (int v = `N_VIRT_CHN - 1; v >= 0; v--) begin
        if (|vc_grant[v]) begin
          act_vld = 1'b1;
          act_vc  = noc_pkg::vc_id_t'(v);
        end
      end
    end
  end

  // grants are one-hot and masked by valid
  always_comb begin : winner_mux
    win_idx = '0;
    for (int k = 0; k < 4; k++) begin
      if (vc_grant[act_vc][k]) win_idx = 2'(k);
    end
    win_flit = fin_flit_i[win_idx];
    win_last = (win_flit.type_f == noc_pkg::TAIL_FLIT) ||
               ((win_flit.type_f == noc_pkg::HEAD_FLIT) &&
                (win_flit.pkt_size == 4'(`MIN_SIZE_FLIT)));
  end

  assign fout_push_o = act_vld && fout_ready_i;  // zero-cycle switch

  always_comb begin : egress_drive
    fout_flit_o.vc_id = act_vc;    // tag with the output vc
    fout_flit_o.flit  = win_flit;
    fin_ready_o       = '0;
    if (act_vld) fin_ready_o[win_idx] = fout_ready_i;  // winner only
    // release only the vc whose last flit really moved
    for (int v = 0; v < `N_VIRT_CHN; v++) begin
      vc_pkt_end[v] = fout_push_o && win_last && (act_vc == noc_pkg::vc_id_t'(v));
    end
  end

endmodule

`default_nettype wire

// File: hdl/rr_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
  parameter int N_OF_INPUTS = 4  // requesters
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n_i,
  input  wire logic [N_OF_INPUTS-1:0] req_i,     // one bit per requester
  input  wire logic                   update_i,  // packet end, release lock
  output logic      [N_OF_INPUTS-1:0] grant_o    // one-hot
);

  localparam int IDX_W = (N_OF_INPUTS > 1) ? $clog2(N_OF_INPUTS) : 1;

  logic [N_OF_INPUTS-1:0] lock_q;     // grant held for the open packet
  logic [IDX_W-1:0]       last_q;     // last winner
  logic [N_OF_INPUTS-1:0] rr_grant;   // fresh round-robin pick
  logic [IDX_W-1:0]       grant_idx;  // encoded grant_o
  logic                   locked;

  assign locked = |lock_q;

  // first requester after the last winner
  always_comb begin : rr_search
    int   idx;
    logic found;
    rr_grant = '0;
    found    = 1'b0;
    for (int i = 1; i <= N_OF_INPUTS; i++) begin
      idx = (int'(last_q) + i) % N_OF_INPUTS;
      if (!found && req_i[idx]) begin
        rr_grant[idx] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  // locked owner only shows a grant while it has a flit
  assign grant_o = locked ? (lock_q & req_i) : rr_grant;

  always_comb begin : grant_encode
    grant_idx = '0;
    for (int i = 0; i < N_OF_INPUTS; i++) begin
      if (grant_o[i]) grant_idx = IDX_W'(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= '0;
      last_q <= IDX_W'(N_OF_INPUTS - 1);  // input 0 goes first
    end else if (update_i) begin
      lock_q <= '0;                       // packet done
      last_q <= grant_idx;                // pointer moves past winner
    end else if (!locked) begin
      lock_q <= rr_grant;                 // hold pick until packet end
    end
  end

endmodule

`default_nettype wire

// File: hdl/vc_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module vc_fifo #(
  parameter type payload_t = logic [7:0],  // stored word
  parameter int  DEPTH     = 4             // number of entries
) (
  input  wire logic     clk,
  input  wire logic     rst_n_i,
  input  wire logic     push_i,   // write request
  input  wire payload_t data_i,   // write data
  input  wire logic     pop_i,    // read request
  output payload_t      data_o,   // head entry, always visible
  output logic          empty_o,
  output logic          full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];  // circular storage
  logic [PTR_W-1:0] wr_ptr_q;       // next free slot
  logic [PTR_W-1:0] rd_ptr_q;       // head slot
  logic [CNT_W-1:0] count_q;        // occupancy
  logic             do_push;
  logic             do_pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;   // push on full dropped
  assign do_pop  = pop_i && !empty_o;   // pop on empty dropped
  assign data_o  = mem_q[rd_ptr_q];     // show-ahead head

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither, level unchanged
      endcase
    end
  end

  // storage, written only on accepted push
  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

// File: verification/noc_output_port_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module noc_output_port_asserts (
  input wire logic                  clk,
  input wire logic                  rst_n_i,
  input wire logic            [3:0] in_valid_i,
  input wire logic            [3:0] in_ready_o,
  input wire logic                  out_valid_o,
  input wire noc_pkg::vc_id_t       out_vc_o,
  input wire noc_pkg::flit_t        out_flit_o,
  input wire logic                  out_ready_i
);

  int   err_cnt = 0;  // failed assertions, polled by the testbench
  logic wr_seen_q;    // some input write since reset

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) wr_seen_q <= 1'b0;
    else if (|(in_valid_i & in_ready_o)) wr_seen_q <= 1'b1;
  end

  // egress buffer is cleared by reset
  a_reset_idle: assert property (@(posedge clk) !rst_n_i |-> !out_valid_o)
    else begin $error("out_valid_o high during reset"); err_cnt++; end

  // empty network until the first write
  a_empty_net: assert property (@(posedge clk) disable iff (!rst_n_i)
    !wr_seen_q |-> (!out_valid_o && (&in_ready_o)))
    else begin $error("port not idle before first write"); err_cnt++; end

  // held flit must not move while the link stalls
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_vc_o) && $stable(out_flit_o)))
    else begin $error("output changed under stall"); err_cnt++; end

endmodule

`default_nettype wire

// File: verification/noc_output_port_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_settings.svh"

module noc_output_port_tb;

  localparam int N_RAND_PKT = 10;  // packets per source, random phases
  localparam int N_RR_PKT   = 6;   // packets per source, round-robin phase
  localparam int MAX_LEN    = 6;   // longest packet in flits
  localparam int N_PKT      = 4 * (2 * N_RAND_PKT + 3 + N_RR_PKT) + 2;

  logic                  clk = 1'b0;
  logic                  rst_n_i;
  logic            [3:0] in_valid_i;
  noc_pkg::vc_id_t [3:0] in_vc_i;
  noc_pkg::flit_t  [3:0] in_flit_i;
  logic            [3:0] in_ready_o;
  logic                  out_valid_o;
  noc_pkg::vc_id_t       out_vc_o;
  noc_pkg::flit_t        out_flit_o;
  logic                  out_ready_i;

  integer                           seed = 32'h525d_0686;
  noc_pkg::flit_t                   src_q [4][$];  // flits not yet written, per source
  logic                       [3:0] took;          // input handshake before next edge
  logic                             stall = 1'b0;  // hold out_ready_i low
  int                               n_gen = 0;     // flits queued
  int                               n_sent = 0;    // flits accepted at inputs
  int                               n_recv = 0;    // flits seen at output
  int                               gen_seq  [4][`N_VIRT_CHN] = '{default: 0};
  int                               next_seq [4][`N_VIRT_CHN] = '{default: 0};
  int                               pend [`N_VIRT_CHN][4] = '{default: 0};  // heads inside
  logic [`N_VIRT_CHN-1:0]           pkt_open = '0;  // open packet per output vc
  int                               open_src [`N_VIRT_CHN];
  int                               exp_idx  [`N_VIRT_CHN];
  int                               last_idx [`N_VIRT_CHN];
  logic [`N_VIRT_CHN-1:0][3:0][3:0] owe = '0;  // sources owed a turn before this one
  logic                             rr_chk = 1'b0;
  logic                             prio_chk = 1'b0;
  logic                             prio_seen = 1'b0;

  noc_output_port u_noc_output_port (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_vc_i     (in_vc_i),
    .in_flit_i   (in_flit_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_vc_o    (out_vc_o),
    .out_flit_o  (out_flit_o),
    .out_ready_i (out_ready_i)
  );

  bind noc_output_port noc_output_port_asserts u_noc_output_port_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_vc_o    (out_vc_o),
    .out_flit_o  (out_flit_o),
    .out_ready_i (out_ready_i)
  );

  always #5 clk = ~clk;  // 10 ns period

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic int rand_below(input int n);
    rand_below = int'($unsigned($random(seed)) % n);
  endfunction

  // data = {src, vc, per-source-per-vc packet number, index in packet}
  task automatic add_packet(input int src, input int vc, input int len);
    noc_pkg::flit_t f;
    for (int i = 0; i < len; i++) begin
      f.type_f   = (i == 0) ? noc_pkg::HEAD_FLIT :
                   (i == len - 1) ? noc_pkg::TAIL_FLIT : noc_pkg::BODY_FLIT;
      f.pkt_size = 4'(len - 1);
      f.data     = {2'(src), 2'(vc), 12'(gen_seq[src][vc]), 16'(i)};
      src_q[src].push_back(f);
    end
    gen_seq[src][vc]++;
    n_gen += len;
  endtask

  task automatic load_random(input int n);
    for (int k = 0; k < 4; k++) begin
      for (int p = 0; p < n; p++) add_packet(k, rand_below(`N_VIRT_CHN), 1 + rand_below(MAX_LEN));
    end
  endtask

  task automatic wait_drain();
    while (n_recv != n_gen) @(posedge clk);  // watchdog bounds this
    repeat (4) @(posedge clk);
  endtask

  task automatic check_flit(input noc_pkg::vc_id_t vc, input noc_pkg::flit_t f);
    int src;
    int seq;
    int idx;
    src = int'(f.data[31:30]);
    seq = int'(f.data[27:16]);
    idx = int'(f.data[15:0]);
    n_recv++;
    assert (int'(f.data[29:28]) == int'(vc)) else report_fail($sformatf(
      "MISMATCH at %0t: out_vc_o %0d, flit written on vc %0d", $time, vc, f.data[29:28]));
    if (!pkt_open[vc]) begin
      assert (f.type_f == noc_pkg::HEAD_FLIT && idx == 0 && seq == next_seq[src][vc])
        else report_fail($sformatf("MISMATCH at %0t: vc %0d expected head %0d of src %0d",
                                   $time, vc, next_seq[src][vc], src));
      pend[vc][src]--;
      if (rr_chk) begin  // everyone waiting at our last turn must have gone first
        assert (owe[vc][src] == '0) else report_fail($sformatf(
          "MISMATCH at %0t: src %0d served twice on vc %0d while %b waited",
          $time, src, vc, owe[vc][src]));
        for (int j = 0; j < 4; j++) begin
          owe[vc][j][src] = 1'b0;
          owe[vc][src][j] = (j != src) && (pend[vc][j] > 0);
        end
      end
      if (prio_chk && !prio_seen) begin
        assert (int'(vc) == (`H_PRIORITY ? `N_VIRT_CHN - 1 : 0)) else report_fail($sformatf(
          "MISMATCH at %0t: first packet left on vc %0d", $time, vc));
        prio_seen = 1'b1;
      end
      pkt_open[vc] = (f.pkt_size != 4'(`MIN_SIZE_FLIT));
      open_src[vc] = src;
      last_idx[vc] = int'(f.pkt_size);
      exp_idx[vc]  = 1;
      if (!pkt_open[vc]) next_seq[src][vc]++;
    end else begin
      assert (src == open_src[vc] && seq == next_seq[src][vc] && idx == exp_idx[vc] &&
              f.type_f == ((idx == last_idx[vc]) ? noc_pkg::TAIL_FLIT : noc_pkg::BODY_FLIT))
        else report_fail($sformatf("MISMATCH at %0t: vc %0d got src %0d pkt %0d idx %0d",
                                   $time, vc, src, seq, idx));
      exp_idx[vc]++;
      if (idx == last_idx[vc]) begin
        pkt_open[vc] = 1'b0;
        next_seq[src][vc]++;
      end
    end
  endtask

  // drive 1 ns after the edge, pop what the last edge accepted
  always @(posedge clk) begin
    #1;
    for (int k = 0; k < 4; k++) begin
      if (took[k]) void'(src_q[k].pop_front());
      in_valid_i[k] = (src_q[k].size() != 0);
      if (src_q[k].size() != 0) begin
        in_flit_i[k] = src_q[k][0];
        in_vc_i[k]   = noc_pkg::vc_id_t'(src_q[k][0].data[29:28]);
      end
    end
    out_ready_i = !stall && (rand_below(4) != 0);
  end

  // sample mid-cycle, where inputs and outputs are settled
  always @(negedge clk) begin
    if (out_valid_o && out_ready_i) check_flit(out_vc_o, out_flit_o);
    for (int k = 0; k < 4; k++) begin
      took[k] = in_valid_i[k] && in_ready_o[k];
      if (took[k]) begin
        n_sent++;
        if (in_flit_i[k].type_f == noc_pkg::HEAD_FLIT) pend[in_vc_i[k]][k]++;
      end
    end
    if (u_noc_output_port.u_noc_output_port_asserts.err_cnt != 0)
      report_fail("a bound assertion on the output port failed");
  end

  initial begin : watchdog
    repeat (N_PKT * MAX_LEN * 40) @(posedge clk);
    report_fail("run timed out, flits stopped reaching the output");
  end

  initial begin : main_seq
    rst_n_i     = 1'b0;
    in_valid_i  = '0;
    in_vc_i     = '0;
    in_flit_i   = '0;
    out_ready_i = 1'b0;
    took        = '0;
    repeat (16) @(posedge clk);
    #1 rst_n_i = 1'b1;
    @(posedge clk);
    load_random(N_RAND_PKT);
    wait_drain();
    stall = 1'b1;  // egress, then inputs, fill up
    for (int k = 0; k < 4; k++) begin
      for (int p = 0; p < 3; p++) add_packet(k, rand_below(`N_VIRT_CHN), MAX_LEN);
    end
    repeat (60) @(posedge clk);
    @(negedge clk);
    assert (in_ready_o == '0 && out_valid_o) else report_fail($sformatf(
      "MISMATCH at %0t: in_ready_o %b under stall", $time, in_ready_o));
    @(posedge clk);
    stall = 1'b0;
    wait_drain();
    owe    = '0;
    rr_chk = 1'b1;  // all four inputs compete on vc 0
    for (int p = 0; p < N_RR_PKT; p++) begin
      for (int k = 0; k < 4; k++) add_packet(k, 0, 1 + rand_below(MAX_LEN));
    end
    wait_drain();
    rr_chk   = 1'b0;
    prio_chk = 1'b1;
    add_packet(0, 0, 3);
    add_packet(1, 1, 3);
    wait_drain();
    prio_chk = 1'b0;
    assert (prio_seen) else report_fail("priority phase produced no packet");
    load_random(N_RAND_PKT);
    wait_drain();
    if (n_recv != n_gen || n_sent != n_gen || pkt_open != '0) begin
      report_fail($sformatf("MISMATCH at %0t: sent %0d, received %0d of %0d flits",
                            $time, n_sent, n_recv, n_gen));
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
